// ==== hw/dd_rom_defines.svh ====
//////////////////////////////
// Slot order is main, char, scroll, object
// Offsets are SDRAM word addresses and must leave room for the
// whole client space of their slot
//////////////////////////////
`ifndef DD_ROM_DEFINES_SVH
`define DD_ROM_DEFINES_SVH

// Clients sharing the SDRAM
`define DD_ROM_SLOTS     4
`define DD_ROM_SDRAM_AW  22
`define DD_ROM_CLIENT_AW 18

// Bank base per slot
`define DD_ROM_OFFSET_0  22'h00_0000
`define DD_ROM_OFFSET_1  22'h02_8000
`define DD_ROM_OFFSET_2  22'h04_0000
`define DD_ROM_OFFSET_3  22'h08_0000

// 1 for 16-bit clients, 0 for 8-bit clients
`define DD_ROM_WIDE_0    1'b0
`define DD_ROM_WIDE_1    1'b0
`define DD_ROM_WIDE_2    1'b1
`define DD_ROM_WIDE_3    1'b1

`endif

// ==== hw/dd_rom_pkg.sv ====
//////////////////////////////
// Lane 0 of a word sits in its low bits
// 8-bit clients get their byte zero-extended to 16 bits
//////////////////////////////
`include "dd_rom_defines.svh"

package dd_rom_pkg;

    // Request as driven by one client
    typedef struct packed {
        logic                         cs;
        logic [`DD_ROM_CLIENT_AW-1:0] addr;
    } rom_client_t;

    // Request after bank mapping
    typedef struct packed {
        logic                        cs;
        logic [`DD_ROM_SDRAM_AW-1:0] word_addr;
        logic [1:0]                  sel;
    } rom_req_t;

    // One SDRAM word, read as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } sdram_word_t;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } rom_resp_t;

endpackage

// ==== hw/dd_rom_map.sv ====
//////////////////////////////
// Output lags the client inputs by one cycle
// No overflow check on offset plus address
//////////////////////////////
`timescale 1ns/1ps
`include "dd_rom_defines.svh"

module dd_rom_map
    import dd_rom_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  rom_client_t client_req [`DD_ROM_SLOTS],
    output rom_req_t    req        [`DD_ROM_SLOTS]
);

    localparam int slots = `DD_ROM_SLOTS;
    localparam int aw    = `DD_ROM_SDRAM_AW;

    localparam logic [aw-1:0] offset [slots] = '{
        `DD_ROM_OFFSET_0,
        `DD_ROM_OFFSET_1,
        `DD_ROM_OFFSET_2,
        `DD_ROM_OFFSET_3
    };

    localparam bit [slots-1:0] wide = {
        `DD_ROM_WIDE_3, `DD_ROM_WIDE_2, `DD_ROM_WIDE_1, `DD_ROM_WIDE_0
    };

    logic [aw-1:0] addr_ext [slots];
    rom_req_t      mapped   [slots];

    always_comb begin
        for (int i = 0; i < slots; i++) begin
            addr_ext[i]  = aw'(client_req[i].addr);
            mapped[i].cs = client_req[i].cs;
            if (wide[i]) begin
                // Two halfwords per SDRAM word
                mapped[i].word_addr = offset[i] + (addr_ext[i] >> 1);
                mapped[i].sel       = {1'b0, client_req[i].addr[0]};
            end else begin
                mapped[i].word_addr = offset[i] + (addr_ext[i] >> 2);
                mapped[i].sel       = client_req[i].addr[1:0];
            end
        end
    end

    // Adders stay off the cache compare path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < slots; i++) begin
                req[i] <= '0;
            end
        end else begin
            for (int i = 0; i < slots; i++) begin
                req[i] <= mapped[i];
            end
        end
    end

endmodule

// ==== hw/dd_rom_slot.sv ====
//////////////////////////////
// Client must hold cs and address until ok
// Downloading drops the cached word
//////////////////////////////
`timescale 1ns/1ps
`include "dd_rom_defines.svh"

module dd_rom_slot
    import dd_rom_pkg::*;
#(
    parameter bit wide = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rom_req_t                    req,
    input  logic                        downloading,
    input  logic                        fill,
    input  sdram_word_t                 fill_data,
    output logic                        pending,
    output logic [`DD_ROM_SDRAM_AW-1:0] word_addr,
    output rom_resp_t                   resp
);

    sdram_word_t                 cache;
    logic [`DD_ROM_SDRAM_AW-1:0] tag;
    logic                        valid;
    logic                        hit;
    sdram_word_t                 src;
    logic [15:0]                 lane;

    assign word_addr = req.word_addr;
    assign hit       = valid && (tag == req.word_addr);

    // A fill answers the client directly, one cycle ahead of the hit path
    assign src = fill ? fill_data : cache;

    always_comb begin
        if (wide) begin
            lane = src.halves[req.sel[0]];
        end else begin
            lane = {8'd0, src.bytes[req.sel]};
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            cache <= fill_data;
            tag   <= req.word_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= 1'b0;
            pending <= 1'b0;
            resp    <= '0;
        end else if (downloading) begin
            valid   <= 1'b0;
            pending <= 1'b0;
            resp.ok <= 1'b0;
        end else begin
            if (fill) begin
                valid <= 1'b1;
            end
            // Miss stays pending until its fill
            pending <= req.cs && !hit && !fill;
            resp.ok <= req.cs && (hit || fill);
            if (req.cs && (hit || fill)) begin
                resp.data <= lane;
            end
        end
    end

endmodule

// ==== hw/dd_rom_sdram_arb.sv ====
//////////////////////////////
// One SDRAM request in flight at a time
// Expects exactly one data_rdy per sdram_ack
//////////////////////////////
`timescale 1ns/1ps
`include "dd_rom_defines.svh"

module dd_rom_sdram_arb
    import dd_rom_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  logic [`DD_ROM_SLOTS-1:0]    pending,
    input  logic [`DD_ROM_SDRAM_AW-1:0] slot_addr [`DD_ROM_SLOTS],
    output logic                        sdram_req,
    output logic [`DD_ROM_SDRAM_AW-1:0] sdram_addr,
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    input  logic [31:0]                 data_read,
    output logic [`DD_ROM_SLOTS-1:0]    fill,
    output sdram_word_t                 fill_data
);

    localparam int slots = `DD_ROM_SLOTS;
    localparam int iw    = $clog2(slots);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_data
    } state_t;

    state_t           state;
    logic [iw-1:0]    last;
    logic [iw-1:0]    cur;
    logic [iw-1:0]    pick;
    logic             found;
    logic             grant;
    logic [slots-1:0] cand;

    // Slot being filled still shows pending for this cycle
    assign cand  = pending & ~fill;
    assign grant = (state == st_idle) && found && !downloading;

    // Round robin from the slot after the last one served
    always_comb begin
        found = 1'b0;
        pick  = last;
        for (int k = 1; k <= slots; k++) begin
            if (!found && cand[(int'(last) + k) % slots]) begin
                found = 1'b1;
                pick  = iw'((int'(last) + k) % slots);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            sdram_req <= 1'b0;
            fill      <= '0;
            cur       <= '0;
            last      <= iw'(slots - 1);
        end else begin
            fill <= '0;
            case (state)
                st_idle: begin
                    if (grant) begin
                        sdram_req <= 1'b1;
                        cur       <= pick;
                        last      <= pick;
                        state     <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= st_wait_data;
                    end
                end
                st_wait_data: begin
                    if (data_rdy) begin
                        // Word fetched across a download is thrown away
                        if (!downloading) begin
                            fill[cur] <= 1'b1;
                        end
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            sdram_addr <= slot_addr[pick];
        end
        if (state == st_wait_data && data_rdy) begin
            fill_data <= data_read;
        end
    end

endmodule

// ==== hw/dd_rom_top.sv ====
//////////////////////////////
// SDRAM controller and refresh live outside
// Slot widths come from the DD_ROM_WIDE macros
//////////////////////////////
`timescale 1ns/1ps
`include "dd_rom_defines.svh"

module dd_rom_top
    import dd_rom_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  rom_client_t                 client_req  [`DD_ROM_SLOTS],
    output rom_resp_t                   client_resp [`DD_ROM_SLOTS],
    input  logic                        downloading,
    // SDRAM side
    output logic                        sdram_req,
    output logic [`DD_ROM_SDRAM_AW-1:0] sdram_addr,
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    input  logic [31:0]                 data_read
);

    localparam bit [`DD_ROM_SLOTS-1:0] slot_wide = {
        `DD_ROM_WIDE_3, `DD_ROM_WIDE_2, `DD_ROM_WIDE_1, `DD_ROM_WIDE_0
    };

    rom_req_t                    req       [`DD_ROM_SLOTS];
    logic [`DD_ROM_SLOTS-1:0]    pending;
    logic [`DD_ROM_SLOTS-1:0]    fill;
    logic [`DD_ROM_SDRAM_AW-1:0] slot_addr [`DD_ROM_SLOTS];
    sdram_word_t                 fill_data;

    dd_rom_map dd_rom_map_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .client_req (client_req),
        .req        (req)
    );

    for (genvar i = 0; i < `DD_ROM_SLOTS; i++) begin : g_slot
        dd_rom_slot #(
            .wide (slot_wide[i])
        ) dd_rom_slot_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .req         (req[i]),
            .downloading (downloading),
            .fill        (fill[i]),
            .fill_data   (fill_data),
            .pending     (pending[i]),
            .word_addr   (slot_addr[i]),
            .resp        (client_resp[i])
        );
    end

    dd_rom_sdram_arb dd_rom_sdram_arb_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .pending     (pending),
        .slot_addr   (slot_addr),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .fill        (fill),
        .fill_data   (fill_data)
    );

endmodule

// ==== tb/dd_rom_assert.sv ====
//////////////////////////////
// Bound into every dd_rom_sdram_arb instance
// Checks are off while rst_n is low
//////////////////////////////
`timescale 1ns/1ps
`include "dd_rom_defines.svh"

module dd_rom_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        downloading,
    input logic                        sdram_req,
    input logic [`DD_ROM_SDRAM_AW-1:0] sdram_addr,
    input logic                        sdram_ack,
    input logic [`DD_ROM_SLOTS-1:0]    fill
);

    int fail_count = 0;

    // Request level and address hold until the ack
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
    else begin
        $error("sdram_req or sdram_addr changed before sdram_ack");
        fail_count++;
    end

    // At most one slot filled per cycle
    fill_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(fill))
    else begin
        $error("fill has more than one bit set");
        fail_count++;
    end

    // Grant is blocked while ROM download runs
    no_req_in_download: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !$past(downloading))
    else begin
        $error("sdram_req rose while downloading was high");
        fail_count++;
    end

endmodule

bind dd_rom_sdram_arb dd_rom_assert dd_rom_assert_i (.*);

// ==== tb/dd_rom_tb.sv ====
//////////////////////////////
// Stimulus read from tb/dd_rom_stim.txt, run from the project root
// SDRAM model returns {addr[15:0], ~addr[15:0]}
//////////////////////////////
`timescale 1ns/1ps
`include "dd_rom_defines.svh"

module dd_rom_tb
    import dd_rom_pkg::*;
();

    localparam int period          = 10;
    localparam int slots           = `DD_ROM_SLOTS;
    localparam int max_lines       = 64;
    localparam int cycles_per_line = 200;
    localparam int reset_cycles    = 8;
    localparam int idle_cycles     = 3;
    localparam int dl_cycles       = 6;

    // Bank base and client width per slot
    localparam logic [`DD_ROM_SDRAM_AW-1:0] bank_base [slots] = '{
        `DD_ROM_OFFSET_0, `DD_ROM_OFFSET_1, `DD_ROM_OFFSET_2, `DD_ROM_OFFSET_3
    };
    localparam bit [slots-1:0] slot_wide = {
        `DD_ROM_WIDE_3, `DD_ROM_WIDE_2, `DD_ROM_WIDE_1, `DD_ROM_WIDE_0
    };

    logic                        clk;
    logic                        rst_n;
    logic                        downloading;
    logic                        sdram_req;
    logic [`DD_ROM_SDRAM_AW-1:0] sdram_addr;
    logic                        sdram_ack;
    logic                        data_rdy;
    logic [31:0]                 data_read;
    rom_client_t                 client_req  [slots];
    rom_resp_t                   client_resp [slots];

    logic [31:0]                 stim      [4*max_lines];
    logic [15:0]                 last_data [slots];
    logic [`DD_ROM_SDRAM_AW-1:0] fetch_addr = '0;
    int                          n_lines   = 0;
    int                          req_count = 0;
    bit                          loaded    = 1'b0;

    dd_rom_top dd_rom_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .client_req  (client_req),
        .client_resp (client_resp),
        .downloading (downloading),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

    always #(period / 2) clk = ~clk;

    // Inputs change 1 ns after the edge, outputs are read there too
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] sdram_word(input logic [`DD_ROM_SDRAM_AW-1:0] addr);
        return {addr[15:0], ~addr[15:0]};
    endfunction

    // Bank base plus the client address counted in SDRAM words
    function automatic logic [`DD_ROM_SDRAM_AW-1:0] mapped_addr(input int slot,
                                                                input logic [17:0] addr);
        if (slot_wide[slot]) begin
            return bank_base[slot] + addr[17:1];
        end else begin
            return bank_base[slot] + addr[17:2];
        end
    endfunction

    task automatic check_resp(input rom_resp_t actual, input rom_resp_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s gave ok=%0b data=%h, expected ok=%0b data=%h",
                     $time, what, actual.ok, actual.data, expected.ok, expected.data);
            $display("RESULT: FAIL");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Fail at %0t: %s, SDRAM requests %0d, expected %0d",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "request count mismatch");
        end
    endtask

    task automatic check_addr(input logic [`DD_ROM_SDRAM_AW-1:0] actual,
                              input logic [`DD_ROM_SDRAM_AW-1:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s, SDRAM address %h, expected %h",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    // Every slot idle, data holds the last word delivered
    task automatic expect_idle();
        rom_resp_t want;
        for (int s = 0; s < slots; s++) begin
            want.ok   = 1'b0;
            want.data = last_data[s];
            check_resp(client_resp[s], want, $sformatf("idle slot %0d", s));
        end
    endtask

    task automatic collect_resp(input int slot, input logic [15:0] exp);
        rom_resp_t want;
        want.ok   = 1'b1;
        want.data = exp;
        step();
        while (client_resp[slot].ok !== 1'b1) begin
            step();
        end
        check_resp(client_resp[slot], want, $sformatf("slot %0d read", slot));
        client_req[slot] = '0;
        last_data[slot]  = exp;
        repeat (idle_cycles) step();
        expect_idle();
    endtask

    task automatic read_one(input int slot, input logic [17:0] addr,
                            input logic [15:0] exp, input int fetches);
        int start;
        start = req_count;
        client_req[slot].cs   = 1'b1;
        client_req[slot].addr = addr;
        collect_resp(slot, exp);
        check_count(req_count, start + fetches, $sformatf("slot %0d single read", slot));
        if (fetches > 0) begin
            check_addr(fetch_addr, mapped_addr(slot, addr), $sformatf("slot %0d fetch", slot));
        end
    endtask

    // All lines of the group raise cs in the same cycle
    task automatic read_group(input int first, input int count);
        int          start;
        int          left;
        int          slot;
        bit          busy     [slots];
        logic [15:0] exp_data [slots];
        rom_resp_t   want;
        start = req_count;
        left  = count;
        for (int s = 0; s < slots; s++) begin
            busy[s] = 1'b0;
        end
        for (int k = 0; k < count; k++) begin
            slot                  = int'(stim[4*(first+k)+1]);
            busy[slot]            = 1'b1;
            exp_data[slot]        = stim[4*(first+k)+3][15:0];
            client_req[slot].cs   = 1'b1;
            client_req[slot].addr = stim[4*(first+k)+2][17:0];
        end
        while (left > 0) begin
            step();
            for (int s = 0; s < slots; s++) begin
                if (busy[s] && client_resp[s].ok === 1'b1) begin
                    want.ok   = 1'b1;
                    want.data = exp_data[s];
                    check_resp(client_resp[s], want, $sformatf("group slot %0d", s));
                    client_req[s] = '0;
                    last_data[s]  = exp_data[s];
                    busy[s]       = 1'b0;
                    left--;
                end
            end
        end
        repeat (idle_cycles) step();
        expect_idle();
        check_count(req_count, start + count, "parallel reads");
    endtask

    // Cached word must be dropped by the download
    task automatic download_then_read(input int slot, input logic [17:0] addr,
                                      input logic [15:0] exp);
        int start;
        start                 = req_count;
        downloading           = 1'b1;
        client_req[slot].cs   = 1'b1;
        client_req[slot].addr = addr;
        repeat (dl_cycles) begin
            step();
            expect_idle();
        end
        downloading = 1'b0;
        collect_resp(slot, exp);
        check_count(req_count, start + 1, $sformatf("slot %0d read after download", slot));
        check_addr(fetch_addr, mapped_addr(slot, addr), $sformatf("slot %0d refetch", slot));
    endtask

    initial begin : sdram_model
        int                          ack_wait;
        int                          data_wait;
        logic [`DD_ROM_SDRAM_AW-1:0] addr;
        void'($urandom(32'h4db99e2f));
        forever begin
            step();
            if (rst_n && sdram_req) begin
                req_count++;
                addr       = sdram_addr;
                fetch_addr = addr;
                ack_wait   = $urandom_range(4, 1);
                repeat (ack_wait - 1) step();
                sdram_ack = 1'b1;
                step();
                sdram_ack = 1'b0;
                data_wait = $urandom_range(6, 1);
                repeat (data_wait - 1) step();
                data_read = sdram_word(addr);
                data_rdy  = 1'b1;
                step();
                data_rdy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        #(period * (reset_cycles + cycles_per_line * n_lines));
        $display("Timeout: the run did not finish in time for %0d stimulus lines", n_lines);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int op;
        int n;
        int i;
        clk         = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        sdram_ack   = 1'b0;
        data_rdy    = 1'b0;
        data_read   = '0;
        for (int s = 0; s < slots; s++) begin
            client_req[s] = '0;
            last_data[s]  = '0;
        end
        $readmemh("tb/dd_rom_stim.txt", stim);
        while (n_lines < max_lines && stim[4*n_lines] != 0) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            $display("No stimulus lines could be read from tb/dd_rom_stim.txt");
            $display("RESULT: FAIL");
            $fatal(1, "missing stimulus");
        end
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // No cs yet, so nothing may move
        repeat (8) begin
            step();
            expect_idle();
        end
        check_count(req_count, 0, "requests before any cs");
        i = 0;
        while (i < n_lines) begin
            op = int'(stim[4*i]);
            case (op)
                1, 2: begin
                    read_one(int'(stim[4*i+1]), stim[4*i+2][17:0], stim[4*i+3][15:0],
                             (op == 1) ? 1 : 0);
                    i++;
                end
                3: begin
                    n = 0;
                    while (i + n < n_lines && stim[4*(i+n)] == 3) begin
                        n++;
                    end
                    read_group(i, n);
                    i += n;
                end
                4: begin
                    download_then_read(int'(stim[4*i+1]), stim[4*i+2][17:0],
                                       stim[4*i+3][15:0]);
                    i++;
                end
                default: begin
                    $display("Unknown operation %0d on stimulus line %0d", op, i);
                    $display("RESULT: FAIL");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end
        if (dd_rom_top_i.dd_rom_sdram_arb_i.dd_rom_assert_i.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Protocol assertions failed during the run");
            $display("RESULT: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== dd_rom.f ====
+incdir+hw
hw/dd_rom_pkg.sv
hw/dd_rom_map.sv
hw/dd_rom_slot.sv
hw/dd_rom_sdram_arb.sv
hw/dd_rom_top.sv
tb/dd_rom_assert.sv
tb/dd_rom_tb.sv

// ==== tb/dd_rom_stim.txt ====
// Columns: op slot client_addr expected_data, all hex
// op 1 read that needs an SDRAM fetch, 2 read served from the cached word
// op 3 lines in a row are issued together, 4 read after a download pulse, 0 ends
1 0 01234 0072
2 0 01237 0004
2 0 01235 00fb
2 0 01236 008d
1 1 3a5c6 0071
2 1 3a5c4 008e
1 2 12345 91a2
2 2 12344 6e5d
1 3 2fffe 8000
2 3 2ffff 7fff
1 0 3fffc 0000
2 0 3fffe 00ff
3 0 0abcf 002a
3 1 00001 007f
3 2 3ffff ffff
3 3 00202 fefe
2 0 0abcc 000c
4 0 0abcd 00d5
4 3 00203 0101
2 3 00202 fefe
3 1 10001 003f
3 3 1abcd d5e6
2 1 10003 00c0
0 0 00000 0000
